// File: msx_fmpac.f
source/fmpac_pkg.sv
source/slot_decoder.sv
source/fmpac_mapper.sv
source/opll_port.sv
source/cart_memory.sv
source/fmpac_cart.sv
+incdir+sim
sim/fmpac_cart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FM-PAC cartridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f msx_fmpac.f --top-module fmpac_cart_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vfmpac_cart_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: sim/fmpac_tb_checks.svh
// Each bus driver call takes one clock cycle
task automatic drive_cycle(input logic [15:0] a, input logic [7:0] d, input logic [3:0] strobes);
    @(posedge cpu_bus);
    #2;
    bus        = {a, d, strobes};     // Strobes are mreq, iorq, rd, wr
    rd_pending = 1'b0;
endtask

task automatic idle();
    drive_cycle(16'h0000, 8'h00, 4'b0000);
endtask

task automatic io_write(input logic [7:0] port, input logic [7:0] d);
    drive_cycle({8'h00, port}, d, 4'b0101);
    if (port == SLOT_PORT)
        slot_model = d;
endtask

task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
    drive_cycle(a, d, 4'b1001);
    model_write(a, d);
endtask

task automatic mem_read(input logic [15:0] a);
    drive_cycle(a, 8'h00, 4'b1010);
    exp_rd     = ref_read(a);
    rd_pending = 1'b1;              // Checked in the middle of the cycle
endtask

task automatic read_burst(input int n, input logic [13:0] span);
    for (int i = 0; i < n; i++)
        mem_read(rand_addr(span));
endtask

// Magic bytes go low byte first
task automatic unlock_sram();
    mem_write(16'h5FFE, 8'h4D);
    mem_write(16'h5FFF, 8'h69);
endtask

task automatic check_byte(input string name, input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
        $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
        stop_run();
    end
endtask

task automatic check_opll(input opll_write_t expected, input opll_write_t actual);
    if (actual !== expected) begin
        $display("** Error: opll_write expected %h %h %h, got %h %h %h",
                 expected.valid, expected.reg_addr, expected.value,
                 actual.valid, actual.reg_addr, actual.value);
        stop_run();
    end
endtask

// File: sim/fmpac_cart_tb.sv
`timescale 1ns/1ps

module fmpac_cart_tb
    import fmpac_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_READS    = 8;
    localparam int N_BANK     = 4;
    localparam int N_SRAM     = 16;
    localparam int N_OPLL     = 4;
    // Reset, fixed steps and the loops of all phases
    localparam int TEST_CYCLES = 41 + 4 * N_READS + 8 * N_BANK + 9 * N_SRAM + 5 * N_OPLL;

    typedef struct packed {
        logic [7:0]  enable;
        logic [1:0]  bank;
        logic [15:0] magic;            // Hi byte from 5FFFh
    } block_model_t;

    logic         cpu_bus;
    logic         reset;
    cpu_req_t     bus;
    logic [7:0]   rd_data;
    opll_write_t  opll_write;

    logic [7:0]   slot_model;
    block_model_t blk_model [2];
    logic [7:0]   sram_model [2][SRAM_BYTES];
    logic [7:0]   opll_addr_model;
    opll_write_t  exp_events [$];
    int           exp_due [$];         // Cycle each event is due
    logic [15:0]  saved_addr [$];
    logic [7:0]   exp_rd;
    logic         rd_pending;
    logic [31:0]  lcg_state;
    int           cyc = 0;

    fmpac_cart fmpac_cart_i (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .bus        (bus),
        .rd_data    (rd_data),
        .opll_write (opll_write)
    );

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    `include "fmpac_tb_checks.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Page 1 address with its offset below span
    function automatic logic [15:0] rand_addr(input logic [13:0] span);
        logic [31:0] r;
        r = lcg_next();
        return {2'b01, 14'(r[31:10] % 22'(span))};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    // Bit 1 set when a cartridge answers and bit 0 gives its block
    function automatic logic [1:0] page_block(input logic [15:0] a);
        if (a[15:14] != 2'b01 || !(slot_model[3:2] inside {2'd1, 2'd2}))
            return 2'b00;
        return {1'b1, slot_model[3]};
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] a);
        logic [1:0]   pb;
        logic [13:0]  off;
        logic [15:0]  rom_addr;
        logic         open;
        block_model_t m;
        pb       = page_block(a);
        off      = a[13:0];
        m        = blk_model[pb[0]];
        open     = m.magic == SRAM_MAGIC;
        rom_addr = {m.bank, off};
        if (!pb[1])
            return 8'hFF;
        if (open && off < 14'h1FFE)
            return sram_model[pb[0]][off[12:0]];
        case (off)
            14'h3FF6: return m.enable;
            14'h3FF7: return {6'b0, m.bank};
            14'h1FFE: begin
                if (open)
                    return m.magic[7:0];
            end
            14'h1FFF: begin
                if (open)
                    return m.magic[15:8];
            end
            default: ;
        endcase
        return rom_addr[7:0] + rom_addr[15:8] * 8'd3;    // ROM image rule
    endfunction

    // Register, SRAM and OPLL effects of one CPU write
    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        logic [1:0]   pb;
        logic [13:0]  off;
        block_model_t m;
        pb  = page_block(a);
        off = a[13:0];
        m   = blk_model[pb[0]];
        if (!pb[1])
            return;
        if (m.magic == SRAM_MAGIC && off < 14'h1FFE)
            sram_model[pb[0]][off[12:0]] = d;
        case (off)
            14'h1FFE: begin
                if (!m.enable[4])
                    blk_model[pb[0]].magic[7:0] = d;
            end
            14'h1FFF: begin
                if (!m.enable[4])
                    blk_model[pb[0]].magic[15:8] = d;
            end
            14'h3FF4: opll_addr_model = d;     // Latched even while disabled
            14'h3FF5: begin
                if (m.enable[0]) begin
                    exp_events.push_back({1'b1, opll_addr_model, d});
                    exp_due.push_back(cyc + 2);
                end
            end
            14'h3FF6: begin
                blk_model[pb[0]].enable = d & 8'h11;
                if (d[4])
                    blk_model[pb[0]].magic = 16'h0000;
            end
            14'h3FF7: blk_model[pb[0]].bank = d[1:0];
            default: ;
        endcase
    endtask

    initial begin
        cpu_bus = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_bus = ~cpu_bus;
    end

    always @(posedge cpu_bus)
        cyc <= cyc + 1;

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Watchdog expired, the test sequence did not finish in time");
        stop_run();
    end

    // Compare process samples in the middle of each cycle
    always @(negedge cpu_bus) begin
        if (!reset) begin
            if (rd_pending)
                check_byte("rd_data", exp_rd, rd_data);
            if (opll_write.valid === 1'b1) begin
                if (exp_due.size() == 0 || exp_due[0] != cyc) begin
                    $display("Unexpected OPLL write event at cycle %0d", cyc);
                    stop_run();
                end else begin
                    check_opll(exp_events.pop_front(), opll_write);
                    void'(exp_due.pop_front());
                end
            end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
                $display("Expected OPLL write event missing at cycle %0d", cyc);
                stop_run();
            end
        end
    end

    initial begin
        logic [15:0] a;
        reset           = 1'b1;
        bus             = '0;
        rd_pending      = 1'b0;
        lcg_state       = 32'd85852;
        slot_model      = 8'h00;
        opll_addr_model = 8'h00;
        blk_model       = '{default: '0};
        foreach (sram_model[b, j])
            sram_model[b][j] = 8'h00;
        repeat (2) @(posedge cpu_bus);
        #2;
        reset = 1'b0;

        // Slot decoding with no block, block 0, then block 1
        read_burst(N_READS, 14'h3FFF);
        io_write(SLOT_PORT, 8'h04);
        read_burst(N_READS, 14'h3FFF);
        io_write(SLOT_PORT, 8'h08);
        read_burst(N_READS, 14'h3FFF);

        io_write(SLOT_PORT, 8'h04);
        repeat (N_BANK) begin
            mem_write(16'h7FF7, rand_byte());
            mem_read(16'h7FF7);
            read_burst(6, 14'h3FFF);
        end

        // Locked SRAM area keeps reading ROM
        repeat (N_SRAM) begin
            a = rand_addr(14'h1FFE);
            saved_addr.push_back(a);
            mem_write(a, rand_byte());
            mem_read(a);
        end
        unlock_sram();
        mem_read(16'h5FFE);
        mem_read(16'h5FFF);
        foreach (saved_addr[i])
            mem_read(saved_addr[i]);           // Locked writes left no trace
        foreach (saved_addr[i])
            mem_write(saved_addr[i], rand_byte());
        foreach (saved_addr[i])
            mem_read(saved_addr[i]);

        mem_write(16'h7FF6, rand_byte());
        mem_read(16'h7FF6);
        mem_write(16'h7FF6, rand_byte() | 8'h10);      // Relocks the SRAM
        unlock_sram();
        mem_read(16'h5FFF);
        mem_write(saved_addr[1], 8'hA5);
        mem_read(saved_addr[1]);
        mem_write(16'h7FF6, 8'h01);
        unlock_sram();
        foreach (saved_addr[i])
            mem_read(saved_addr[i]);

        repeat (N_OPLL) begin
            mem_write(16'h7FF4, rand_byte());
            mem_write(16'h7FF5, rand_byte());
            repeat (3) idle();
        end
        mem_write(16'h7FF6, 8'h00);                    // Device off
        mem_write(16'h7FF4, rand_byte());
        mem_write(16'h7FF5, rand_byte());
        repeat (3) idle();
        mem_write(16'h7FF6, 8'h01);

        // Block 1 changes must leave block 0 alone
        io_write(SLOT_PORT, 8'h08);
        mem_write(16'h7FF7, rand_byte());
        unlock_sram();
        foreach (saved_addr[i])
            mem_write(saved_addr[i], rand_byte());
        mem_read(16'h7FF7);
        foreach (saved_addr[i])
            mem_read(saved_addr[i]);
        io_write(SLOT_PORT, 8'h04);
        mem_read(16'h7FF6);
        mem_read(16'h7FF7);
        mem_read(16'h5FFE);
        mem_read(16'h5FFF);
        foreach (saved_addr[i])
            mem_read(saved_addr[i]);
        read_burst(N_READS, 14'h3FFF);
        repeat (4) idle();

        if (exp_events.size() != 0) begin
            $display("%0d expected OPLL write events never appeared", exp_events.size());
            stop_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: source/cart_memory.sv
`timescale 1ns/1ps

module cart_memory
    import fmpac_pkg::*;
(
    input  logic        cpu_bus,
    input  logic [7:0]  bus_data,
    input  logic        block_id,
    input  mapper_out_t map_out,
    output logic [7:0]  rd_data
);

    logic [7:0] rom  [ROM_BYTES];                  // Shared by both blocks
    logic [7:0] sram [BLOCK_COUNT][SRAM_BYTES];    // Battery backed, one per block

    logic [12:0] sram_addr;
    logic [15:0] rom_addr;

    assign sram_addr = map_out.addr[12:0];
    assign rom_addr  = map_out.addr[15:0];

    initial begin
        for (int i = 0; i < ROM_BYTES; i++) begin
            rom[i] = rom_image_byte(16'(i));
        end
        for (int b = 0; b < BLOCK_COUNT; b++) begin
            for (int j = 0; j < SRAM_BYTES; j++) begin
                sram[b][j] = 8'h00;
            end
        end
    end

    always @(posedge cpu_bus) begin
        if (map_out.sram_cs && !map_out.rnw)
            sram[block_id][sram_addr] <= bus_data;
    end

    // SRAM first, then ROM, then the mapper readback
    always_comb begin
        if (map_out.sram_cs)
            rd_data = sram[block_id][sram_addr];
        else if (map_out.ram_cs)
            rd_data = rom[rom_addr];
        else
            rd_data = map_out.data;
    end

endmodule

// File: source/fmpac_cart.sv
`timescale 1ns/1ps

module fmpac_cart
    import fmpac_pkg::*;
(
    input  logic        cpu_bus,
    input  logic        reset,
    input  cpu_req_t    bus,
    output logic [7:0]  rd_data,
    output opll_write_t opll_write
);

    block_info_t block_info;
    mapper_out_t map_out;
    device_bus_t device;

    slot_decoder slot_decoder_i (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .bus        (bus),
        .block_info (block_info)
    );

    fmpac_mapper fmpac_mapper_i (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .bus        (bus),
        .block_info (block_info),
        .map_out    (map_out),
        .device     (device)
    );

    opll_port opll_port_i (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .device     (device),
        .opll_write (opll_write)
    );

    cart_memory cart_memory_i (
        .cpu_bus    (cpu_bus),
        .bus_data   (bus.data),
        .block_id   (block_info.id),
        .map_out    (map_out),
        .rd_data    (rd_data)
    );

endmodule

// File: source/fmpac_mapper.sv
`timescale 1ns/1ps

module fmpac_mapper
    import fmpac_pkg::*;
(
    input  logic        cpu_bus,
    input  logic        reset,
    input  cpu_req_t    bus,
    input  block_info_t block_info,
    output mapper_out_t map_out,
    output device_bus_t device
);

    logic [7:0] enable   [BLOCK_COUNT];    // Bits 0 and 4 only
    logic [1:0] bank     [BLOCK_COUNT];
    logic [7:0] magic_lo [BLOCK_COUNT];
    logic [7:0] magic_hi [BLOCK_COUNT];

    device_bus_t device_q;

    logic [13:0] offset;       // Offset within page 1
    logic        id;
    logic        cs;
    logic        wr_cycle;
    logic        opll_hit;
    logic        unlocked;
    logic        sram_sel;
    logic        reg_hit;

    assign offset   = bus.addr[13:0];
    assign id       = block_info.id;
    assign cs       = (block_info.typ == MAPPER_FMPAC) && bus.mreq;
    assign wr_cycle = cs && bus.wr;
    assign opll_hit = (offset == 14'h3FF4) || (offset == 14'h3FF5);
    assign unlocked = {magic_hi[id], magic_lo[id]} == SRAM_MAGIC;

    assign sram_sel = cs && unlocked && (offset < 14'h1FFE) && (bus.rd || bus.wr);

    // Addresses that answer from a register and not from ROM
    assign reg_hit = (offset == 14'h3FF6) || (offset == 14'h3FF7) ||
                     (unlocked && (offset == 14'h1FFE || offset == 14'h1FFF));

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            enable   <= '{default: 8'h00};
            bank     <= '{default: 2'b00};
            magic_lo <= '{default: 8'h00};
            magic_hi <= '{default: 8'h00};
        end else if (wr_cycle) begin
            case (offset)
                14'h1FFE: begin
                    if (!enable[id][4])
                        magic_lo[id] <= bus.data;
                end
                14'h1FFF: begin
                    if (!enable[id][4])
                        magic_hi[id] <= bus.data;
                end
                14'h3FF6: begin
                    enable[id] <= bus.data & 8'h11;
                    if (bus.data[4]) begin         // Relock the SRAM
                        magic_lo[id] <= 8'h00;
                        magic_hi[id] <= 8'h00;
                    end
                end
                14'h3FF7: bank[id] <= bus.data[1:0];
                default: ;
            endcase
        end
    end

    // OPLL request, held for the cycle after the write
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            device_q <= '0;
        end else begin
            device_q.typ  <= (wr_cycle && opll_hit) ? DEV_OPLL : DEV_NONE;
            device_q.we   <= wr_cycle && opll_hit;
            device_q.en   <= enable[id][0];
            device_q.port <= offset[0];        // 3FF5h is the data port
            device_q.data <= bus.data;
        end
    end

    assign device = device_q;

    always_comb begin
        map_out.sram_cs = sram_sel;
        map_out.ram_cs  = cs && bus.rd && !sram_sel && !reg_hit;
        map_out.rnw     = !(sram_sel && bus.wr);
        map_out.addr    = {27{1'b1}};
        map_out.data    = 8'hFF;

        if (sram_sel)
            map_out.addr = {14'b0, offset[12:0]};
        else if (cs)
            map_out.addr = {11'b0, bank[id], offset};  // 16 KB banks

        if (cs) begin
            case (offset)
                14'h3FF6: map_out.data = enable[id];
                14'h3FF7: map_out.data = {6'b0, bank[id]};
                14'h1FFE: begin
                    if (unlocked)
                        map_out.data = magic_lo[id];
                end
                14'h1FFF: begin
                    if (unlocked)
                        map_out.data = magic_hi[id];
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/fmpac_pkg.sv
package fmpac_pkg;

    // Sizes and fixed values
    localparam int          BLOCK_COUNT  = 2;
    localparam logic [7:0]  SLOT_PORT    = 8'hA8;      // MSX primary slot register
    localparam logic [15:0] SRAM_MAGIC   = 16'h694D;   // Hi byte at 1FFFh, lo at 1FFEh
    localparam int          SRAM_BYTES   = 8192;
    localparam int          ROM_BYTES    = 65536;
    localparam logic [1:0]  FMPAC_SLOT_0 = 2'd1;       // Slot of block 0
    localparam logic [1:0]  FMPAC_SLOT_1 = 2'd2;       // Slot of block 1

    typedef enum logic [1:0] {
        MAPPER_NONE  = 2'd0,
        MAPPER_FMPAC = 2'd1
    } mapper_type_e;

    typedef enum logic [1:0] {
        DEV_NONE = 2'd0,
        DEV_OPLL = 2'd1
    } device_type_e;

    // One Z80 bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        mreq;
        logic        iorq;
        logic        rd;
        logic        wr;
    } cpu_req_t;

    typedef struct packed {
        mapper_type_e typ;
        logic         id;      // Cartridge block number
    } block_info_t;

    typedef struct packed {
        logic        sram_cs;
        logic        ram_cs;
        logic        rnw;
        logic [26:0] addr;     // All ones when nothing selected
        logic [7:0]  data;     // Register readback, FFh if none
    } mapper_out_t;

    typedef struct packed {
        device_type_e typ;
        logic         we;      // One cycle write strobe
        logic         en;
        logic         port;    // 0 address, 1 data
        logic [7:0]   data;
    } device_bus_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] reg_addr;
        logic [7:0] value;
    } opll_write_t;

    // Initial ROM contents, lo byte plus three times hi byte
    function automatic logic [7:0] rom_image_byte(input logic [15:0] addr);
        return 8'(addr[7:0] + 3 * addr[15:8]);
    endfunction

endpackage

// File: source/opll_port.sv
`timescale 1ns/1ps

module opll_port
    import fmpac_pkg::*;
(
    input  logic        cpu_bus,
    input  logic        reset,
    input  device_bus_t device,
    output opll_write_t opll_write
);

    logic       strobe;
    logic [7:0] addr_latch;    // Last register number written
    logic       valid_q;
    logic [7:0] evt_addr;
    logic [7:0] evt_value;

    assign strobe = device.we && (device.typ == DEV_OPLL);

    always_ff @(posedge cpu_bus) begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= strobe && device.port && device.en;  // Muted while disabled
    end

    always_ff @(posedge cpu_bus) begin
        if (strobe && !device.port)
            addr_latch <= device.data;
        if (strobe && device.port) begin
            evt_addr  <= addr_latch;
            evt_value <= device.data;
        end
    end

    assign opll_write.valid    = valid_q;
    assign opll_write.reg_addr = evt_addr;
    assign opll_write.value    = evt_value;

endmodule

// File: source/slot_decoder.sv
`timescale 1ns/1ps

module slot_decoder
    import fmpac_pkg::*;
(
    input  logic        cpu_bus,
    input  logic        reset,
    input  cpu_req_t    bus,
    output block_info_t block_info
);

    logic [7:0] slot_reg;      // Two bits per page, page 0 in bits 1:0
    logic [1:0] page;
    logic [1:0] page1_slot;
    logic       slot_write;

    assign page       = bus.addr[15:14];
    assign page1_slot = slot_reg[3:2];
    assign slot_write = bus.iorq && bus.wr && (bus.addr[7:0] == SLOT_PORT);

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            slot_reg <= 8'h00;
        end else if (slot_write) begin
            slot_reg <= bus.data;
        end
    end

    // Only page 1 reaches a cartridge block
    always_comb begin
        block_info.typ = MAPPER_NONE;
        block_info.id  = 1'b0;
        if (page == 2'b01) begin
            if (page1_slot == FMPAC_SLOT_0) begin
                block_info.typ = MAPPER_FMPAC;
                block_info.id  = 1'b0;
            end else if (page1_slot == FMPAC_SLOT_1) begin
                block_info.typ = MAPPER_FMPAC;
                block_info.id  = 1'b1;
            end
        end
    end

endmodule
